// File: logic/core_defines.svh
// Shared widths, depths and latencies; ROB_SLOTS and QUEUE_DEPTH must stay powers of two
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Data and instruction words
`define ARCH_BITS 32
`define INST_BITS 32
`define OPCODE_BITS 7

// 32 architectural registers
`define REG_IDX_BITS 5

// Reorder buffer, ROB_SLOTS = 2**ROB_IDX_BITS
`define ROB_IDX_BITS 3
`define ROB_SLOTS 8

// Input queue depth, also the source's credits after reset
`define QUEUE_DEPTH 4

// Credits held for the sink after reset
`define COMMIT_CREDITS 4
`define MULT_STAGES 3

`endif

// File: logic/corePkg.sv
// Opcode and field types; codes outside the enum decode as NOP
`default_nettype none

`include "core_defines.svh"

package corePkg;

	// Instruction opcodes kept from the full core
	typedef enum logic [`OPCODE_BITS-1:0]
	{
		OP_ADD = 7'h00,
		OP_SUB = 7'h01,
		OP_MUL = 7'h02,
		OP_MOV = 7'h14,
		OP_MOVI = 7'h15,
		OP_NOP = 7'h7f
	} opcodeT;

	// Architectural register index
	typedef logic [`REG_IDX_BITS-1:0] regIdxT;

	// Reorder slot index
	typedef logic [`ROB_IDX_BITS-1:0] robIdxT;

	typedef logic [`ARCH_BITS-1:0] wordT;

endpackage

`default_nettype wire

// File: logic/issueQueue.sv
// Source must hold a credit for every word it sends; writes are not checked against a full queue
`timescale 1ns/10ps
`default_nettype none

`include "core_defines.svh"

module issueQueue
(
	input logic clk,
	input logic rst,
	input logic instValid,
	input logic [`INST_BITS-1:0] inst,
	input logic headTake,
	output logic headValid,
	output logic [`INST_BITS-1:0] headInst,
	output logic instCredit
);
	localparam int PtrBits = $clog2(`QUEUE_DEPTH);
	localparam int CountBits = $clog2(`QUEUE_DEPTH + 1);

	logic [`INST_BITS-1:0] mem [`QUEUE_DEPTH];
	logic [PtrBits-1:0] rdPtr;
	logic [PtrBits-1:0] wrPtr;
	logic [CountBits-1:0] count;
	logic popFire;

	assign headValid = count != '0;
	assign headInst = mem[rdPtr];
	assign popFire = headTake && headValid;

	always_ff @(posedge clk)
	begin
		if (instValid)
			mem[wrPtr] <= inst;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rdPtr <= '0;
			wrPtr <= '0;
			count <= '0;
			instCredit <= 1'b0;
		end
		else
		begin
			if (instValid)
				wrPtr <= wrPtr + 1'b1;
			if (popFire)
				rdPtr <= rdPtr + 1'b1;
			count <= count + CountBits'(instValid) - CountBits'(popFire);
			// One credit back per entry handed to dispatch
			instCredit <= popFire;
		end
	end

endmodule

`default_nettype wire

// File: logic/registerFile.sv
// Reads are combinational; a write lands at the clock edge that ends its cycle
`timescale 1ns/10ps
`default_nettype none

`include "core_defines.svh"

module registerFile
(
	input logic clk,
	input logic rst,
	input corePkg::regIdxT readIdx1,
	input corePkg::regIdxT readIdx2,
	input logic wbEnable,
	input corePkg::regIdxT wbIdx,
	input corePkg::wordT wbData,
	output corePkg::wordT readData1,
	output corePkg::wordT readData2
);
	import corePkg::*;

	wordT regs [2**`REG_IDX_BITS];

	assign readData1 = regs[readIdx1];
	assign readData2 = regs[readIdx2];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < 2**`REG_IDX_BITS; i++)
				regs[i] <= '0;
		end
		else if (wbEnable)
			regs[wbIdx] <= wbData;
	end

endmodule

`default_nettype wire

// File: logic/dispatchUnit.sv
// In-order single issue; waits on pending sources and destination, so no forwarding exists
`timescale 1ns/10ps
`default_nettype none

`include "core_defines.svh"

module dispatchUnit
(
	input logic clk,
	input logic rst,
	input logic headValid,
	input logic [`INST_BITS-1:0] headInst,
	input corePkg::wordT readData1,
	input corePkg::wordT readData2,
	input logic robFull,
	input corePkg::robIdxT robTail,
	input logic wbEnable,
	input corePkg::regIdxT wbIdx,
	output logic headTake,
	output corePkg::regIdxT readIdx1,
	output corePkg::regIdxT readIdx2,
	output logic robAlloc,
	output corePkg::regIdxT allocDst,
	output corePkg::robIdxT allocIdx,
	output logic aluIssue,
	output corePkg::opcodeT aluOp,
	output corePkg::wordT aluA,
	output corePkg::wordT aluB,
	output corePkg::robIdxT aluRob,
	output logic multIssue,
	output corePkg::wordT multA,
	output corePkg::wordT multB,
	output corePkg::robIdxT multRob
);
	import corePkg::*;

	opcodeT opcode;
	regIdxT dst;
	regIdxT src1;
	regIdxT src2;
	wordT imm;
	logic isAlu;
	logic isMul;
	logic useSrc1;
	logic useSrc2;
	logic stall;
	logic issueFire;
	logic [2**`REG_IDX_BITS-1:0] pending;

	// Field decode
	assign opcode = opcodeT'(headInst[31:25]);
	assign dst = headInst[24:20];
	assign src1 = headInst[19:15];
	assign src2 = headInst[14:10];
	assign imm = {{(`ARCH_BITS - 20){headInst[19]}}, headInst[19:0]};

	// Anything outside these sets is a NOP
	assign isMul = opcode == OP_MUL;
	assign isAlu = opcode inside {OP_ADD, OP_SUB, OP_MOV, OP_MOVI};
	assign useSrc1 = opcode inside {OP_ADD, OP_SUB, OP_MUL, OP_MOV};
	assign useSrc2 = opcode inside {OP_ADD, OP_SUB, OP_MUL};

	assign stall = robFull || (useSrc1 && pending[src1]) || (useSrc2 && pending[src2]) ||
		pending[dst];
	assign issueFire = headValid && (isAlu || isMul) && !stall;

	// NOPs leave the queue at once and take no slot
	assign headTake = issueFire || (headValid && !isAlu && !isMul);

	assign readIdx1 = src1;
	assign readIdx2 = src2;
	assign robAlloc = issueFire;
	assign allocDst = dst;
	assign allocIdx = robTail;

	// MOV adds zero to the register, MOVI adds zero to the immediate
	assign aluIssue = issueFire && isAlu;
	assign aluOp = opcode;
	assign aluA = (opcode == OP_MOVI) ? imm : readData1;
	assign aluB = (opcode inside {OP_ADD, OP_SUB}) ? readData2 : '0;
	assign aluRob = robTail;

	assign multIssue = issueFire && isMul;
	assign multA = readData1;
	assign multB = readData2;
	assign multRob = robTail;

	// Scoreboard, a set in the same cycle as a clear wins
	always_ff @(posedge clk)
	begin
		if (rst)
			pending <= '0;
		else
		begin
			if (wbEnable)
				pending[wbIdx] <= 1'b0;
			if (robAlloc)
				pending[allocDst] <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: logic/executeUnit.sv
// MULT_STAGES must be at least 2; only the low word of the product is kept
`timescale 1ns/10ps
`default_nettype none

`include "core_defines.svh"

module executeUnit
(
	input logic clk,
	input logic rst,
	input logic aluIssue,
	input corePkg::opcodeT aluOp,
	input corePkg::wordT aluA,
	input corePkg::wordT aluB,
	input corePkg::robIdxT aluRob,
	input logic multIssue,
	input corePkg::wordT multA,
	input corePkg::wordT multB,
	input corePkg::robIdxT multRob,
	output logic aluDone,
	output corePkg::robIdxT aluDoneRob,
	output corePkg::wordT aluResult,
	output logic multDone,
	output corePkg::robIdxT multDoneRob,
	output corePkg::wordT multResult
);
	import corePkg::*;

	logic [`MULT_STAGES-1:0] multValid;
	robIdxT multRobPipe [`MULT_STAGES];
	wordT multPipe [`MULT_STAGES];

	// Single ALU stage
	always_ff @(posedge clk)
	begin
		if (rst)
			aluDone <= 1'b0;
		else
			aluDone <= aluIssue;
	end

	always_ff @(posedge clk)
	begin
		aluDoneRob <= aluRob;
		aluResult <= (aluOp == OP_SUB) ? aluA - aluB : aluA + aluB;
	end

	// Multiplier pipeline, valid bits shift alongside the data
	always_ff @(posedge clk)
	begin
		if (rst)
			multValid <= '0;
		else
			multValid <= {multValid[`MULT_STAGES-2:0], multIssue};
	end

	always_ff @(posedge clk)
	begin
		multRobPipe[0] <= multRob;
		multPipe[0] <= multA * multB;
		for (int i = 1; i < `MULT_STAGES; i++)
		begin
			multRobPipe[i] <= multRobPipe[i-1];
			multPipe[i] <= multPipe[i-1];
		end
	end

	assign multDone = multValid[`MULT_STAGES-1];
	assign multDoneRob = multRobPipe[`MULT_STAGES-1];
	assign multResult = multPipe[`MULT_STAGES-1];

endmodule

`default_nettype wire

// File: logic/reorderBuffer.sv
// Sink must not return more credits than it was given; commit outputs are combinational
`timescale 1ns/10ps
`default_nettype none

`include "core_defines.svh"

module reorderBuffer
(
	input logic clk,
	input logic rst,
	input logic robAlloc,
	input corePkg::regIdxT allocDst,
	input corePkg::robIdxT allocIdx,
	input logic aluDone,
	input corePkg::robIdxT aluDoneRob,
	input corePkg::wordT aluResult,
	input logic multDone,
	input corePkg::robIdxT multDoneRob,
	input corePkg::wordT multResult,
	input logic commitCredit,
	output logic robFull,
	output corePkg::robIdxT robTail,
	output logic wbEnable,
	output corePkg::regIdxT wbIdx,
	output corePkg::wordT wbData,
	output logic commitValid,
	output corePkg::regIdxT commitDst,
	output corePkg::wordT commitData
);
	import corePkg::*;

	localparam int CountBits = `ROB_IDX_BITS + 1;
	localparam int CreditBits = $clog2(`COMMIT_CREDITS + 1);

	regIdxT dstMem [`ROB_SLOTS];
	wordT dataMem [`ROB_SLOTS];
	logic [`ROB_SLOTS-1:0] done;
	robIdxT head;
	robIdxT tail;
	logic [CountBits-1:0] count;
	logic [CreditBits-1:0] credits;
	logic commitFire;

	assign robFull = count == CountBits'(`ROB_SLOTS);
	assign robTail = tail;

	// Oldest slot retires once finished and the sink has room
	assign commitFire = (count != '0) && done[head] && (credits != '0);

	assign wbEnable = commitFire;
	assign wbIdx = dstMem[head];
	assign wbData = dataMem[head];
	assign commitValid = commitFire;
	assign commitDst = wbIdx;
	assign commitData = wbData;

	always_ff @(posedge clk)
	begin
		if (robAlloc)
			dstMem[allocIdx] <= allocDst;
		if (aluDone)
			dataMem[aluDoneRob] <= aluResult;
		if (multDone)
			dataMem[multDoneRob] <= multResult;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			done <= '0;
			head <= '0;
			tail <= '0;
			count <= '0;
			credits <= CreditBits'(`COMMIT_CREDITS);
		end
		else
		begin
			if (robAlloc)
			begin
				done[allocIdx] <= 1'b0;
				tail <= tail + 1'b1;
			end
			// Both units may finish in the same cycle, always in different slots
			if (aluDone)
				done[aluDoneRob] <= 1'b1;
			if (multDone)
				done[multDoneRob] <= 1'b1;
			if (commitFire)
				head <= head + 1'b1;
			count <= count + CountBits'(robAlloc) - CountBits'(commitFire);
			credits <= credits + CreditBits'(commitCredit) - CreditBits'(commitFire);
		end
	end

endmodule

`default_nettype wire

// File: logic/execCore.sv
// Credit-based ports on both sides; the source starts with QUEUE_DEPTH credits
`timescale 1ns/10ps
`default_nettype none

`include "core_defines.svh"

module execCore
(
	input logic clk,
	input logic rst,
	input logic instValid,
	input logic [`INST_BITS-1:0] inst,
	input logic commitCredit,
	output logic instCredit,
	output logic commitValid,
	output corePkg::regIdxT commitDst,
	output corePkg::wordT commitData
);
	import corePkg::*;

	// Queue to dispatch
	logic headValid;
	logic [`INST_BITS-1:0] headInst;
	logic headTake;

	// Register reads
	regIdxT readIdx1;
	regIdxT readIdx2;
	wordT readData1;
	wordT readData2;

	// Slot allocation
	logic robFull;
	robIdxT robTail;
	logic robAlloc;
	regIdxT allocDst;
	robIdxT allocIdx;

	// Issue ports
	logic aluIssue;
	opcodeT aluOp;
	wordT aluA;
	wordT aluB;
	robIdxT aluRob;
	logic multIssue;
	wordT multA;
	wordT multB;
	robIdxT multRob;

	// Completion ports
	logic aluDone;
	robIdxT aluDoneRob;
	wordT aluResult;
	logic multDone;
	robIdxT multDoneRob;
	wordT multResult;

	// Writeback
	logic wbEnable;
	regIdxT wbIdx;
	wordT wbData;

	issueQueue issueQueue_inst (.*);
	dispatchUnit dispatchUnit_inst (.*);
	registerFile registerFile_inst (.*);
	executeUnit executeUnit_inst (.*);
	reorderBuffer reorderBuffer_inst (.*);

endmodule

`default_nettype wire

// File: verification/commitChecker.sv
// Each expectation must be pushed before its commit appears; NOPs get no expectation
`timescale 1ns/10ps
`default_nettype none

`include "core_defines.svh"

module commitChecker
(
	input logic clk,
	input logic rst,
	input logic commitValid,
	input corePkg::regIdxT commitDst,
	input corePkg::wordT commitData,
	input logic expPush,
	input corePkg::regIdxT expDst,
	input corePkg::wordT expData,
	output int commitCount,
	output int errorCount
);
	import corePkg::*;

	// Outstanding expectations, oldest first
	regIdxT dstQueue [$];
	wordT dataQueue [$];

	always @(posedge clk)
	begin : compare
		regIdxT wantDst;
		wordT wantData;
		int errs;
		errs = 0;
		if (rst)
		begin
			dstQueue.delete();
			dataQueue.delete();
			commitCount <= 0;
			errorCount <= 0;
		end
		else
		begin
			if (commitValid)
			begin
				if (dstQueue.size() == 0)
				begin
					$display("Unexpected commit at %0d ns: r%0d = 0x%h with nothing outstanding",
						$time, commitDst, commitData);
					errs++;
				end
				else
				begin
					wantDst = dstQueue.pop_front();
					wantData = dataQueue.pop_front();
					if (commitDst !== wantDst)
					begin
						$display("FAILED at %0d ns: commitDst = %0d, expected %0d",
							$time, commitDst, wantDst);
						errs++;
					end
					if (commitData !== wantData)
					begin
						$display("FAILED at %0d ns: commitData = 0x%h, expected 0x%h",
							$time, commitData, wantData);
						errs++;
					end
				end
				commitCount <= commitCount + 1;
			end
			// A new expectation never matches a commit in the same cycle
			if (expPush)
			begin
				dstQueue.push_back(expDst);
				dataQueue.push_back(expData);
			end
			errorCount <= errorCount + errs;
		end
	end

endmodule

`default_nettype wire

// File: verification/execCore_asserts.sv
// Bound into reorderBuffer and issueQueue; RobChecks picks the reorder buffer or the queue checks
`timescale 1ns/10ps
`default_nettype none

`include "core_defines.svh"

module execCoreAsserts
#(
	parameter bit RobChecks = 1'b1
)
(
	input logic clk,
	input logic rst,
	input logic commitValid,
	input logic commitCredit,
	input logic [`ROB_IDX_BITS:0] count,
	input logic instCredit,
	input logic headTake,
	input logic headValid
);
	int failures = 0;

	generate
		if (RobChecks)
		begin : robSide
			// Sink credits as seen on the commit port
			int sinkCredits;

			always @(posedge clk)
			begin
				if (rst)
					sinkCredits <= `COMMIT_CREDITS;
				else
					sinkCredits <= sinkCredits + int'(commitCredit) - int'(commitValid);
			end

			// A commit spends a credit
			commitNeedsCredit: assert property (@(posedge clk) disable iff (rst)
				commitValid |-> sinkCredits > 0)
			else
			begin
				$error("commitValid high with no output credit");
				failures++;
			end

			robCountBounded: assert property (@(posedge clk) disable iff (rst)
				count <= `ROB_SLOTS)
			else
			begin
				$error("reorder buffer count above ROB_SLOTS");
				failures++;
			end
		end
		else
		begin : queueSide
			// Credit returns one cycle after an entry leaves the queue
			creditFollowsTake: assert property (@(posedge clk) disable iff (rst)
				instCredit |-> $past(headTake && headValid))
			else
			begin
				$error("instCredit pulsed without a headTake");
				failures++;
			end
		end
	endgenerate

endmodule

bind reorderBuffer execCoreAsserts #(.RobChecks(1'b1)) robAsserts
(
	.clk(clk),
	.rst(rst),
	.commitValid(commitValid),
	.commitCredit(commitCredit),
	.count(count),
	.instCredit(1'b0),
	.headTake(1'b0),
	.headValid(1'b0)
);

bind issueQueue execCoreAsserts #(.RobChecks(1'b0)) queueAsserts
(
	.clk(clk),
	.rst(rst),
	.commitValid(1'b0),
	.commitCredit(1'b0),
	.count('0),
	.instCredit(instCredit),
	.headTake(headTake),
	.headValid(headValid)
);

`default_nettype wire

// File: verification/execCore_tb.sv
// Run from the project root so the test file path resolves; test 4 withholds sink credits a while
`timescale 1ns/10ps
`default_nettype none

`include "core_defines.svh"

module execCore_tb;
	import corePkg::*;

	localparam int Timeout = 400;
	localparam int HoldCycles = 40;
	localparam int NoCommitDst = 2**`REG_IDX_BITS;
	localparam int LastTest = 5;

	logic clk;
	logic rst;
	logic instValid;
	logic [`INST_BITS-1:0] inst;
	logic commitCredit = 1'b0;
	logic instCredit;
	logic commitValid;
	regIdxT commitDst;
	wordT commitData;

	// Expectation port of the checker
	logic expPush;
	regIdxT expDst;
	wordT expData;
	int commitCount;
	int errorCount;

	// Test file contents, one entry per line
	int testNum [$];
	logic [`INST_BITS-1:0] instWord [$];
	int wantDst [$];
	wordT wantData [$];

	int creditsBack;
	int sent;
	int owed;
	int gap;
	logic holdCredits;
	integer seed = 32'hd14f_c79c;
	int expTotal;
	int localErrors;
	logic timedOut;
	logic fileError;

	execCore execCore_inst
	(
		.clk(clk),
		.rst(rst),
		.instValid(instValid),
		.inst(inst),
		.commitCredit(commitCredit),
		.instCredit(instCredit),
		.commitValid(commitValid),
		.commitDst(commitDst),
		.commitData(commitData)
	);

	commitChecker commitCheckerInst
	(
		.clk(clk),
		.rst(rst),
		.commitValid(commitValid),
		.commitDst(commitDst),
		.commitData(commitData),
		.expPush(expPush),
		.expDst(expDst),
		.expData(expData),
		.commitCount(commitCount),
		.errorCount(errorCount)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#4 clk = ~clk;
	end

	// Input credits handed back by the queue
	always @(posedge clk)
	begin
		if (rst)
			creditsBack <= 0;
		else if (instCredit)
			creditsBack <= creditsBack + 1;
	end

	// Sink returns one credit per commit after a random gap
	always @(posedge clk)
	begin : sink
		int nextOwed;
		int nextGap;
		nextOwed = owed + (commitValid ? 1 : 0);
		nextGap = (gap > 0) ? gap - 1 : 0;
		commitCredit <= 1'b0;
		if (rst)
		begin
			nextOwed = 0;
			nextGap = 0;
		end
		else if (nextOwed > 0 && nextGap == 0 && !holdCredits)
		begin
			commitCredit <= 1'b1;
			nextOwed = nextOwed - 1;
			nextGap = $random(seed) & 7;
		end
		owed <= nextOwed;
		gap <= nextGap;
	end

	task automatic loadTests();
		int fd;
		int t;
		int dst;
		logic [`INST_BITS-1:0] word;
		logic [`ARCH_BITS-1:0] data;
		string line;
		begin
			fd = $fopen("verification/execCore_tests.txt", "r");
			if (fd == 0)
			begin
				$display("Could not open verification/execCore_tests.txt");
				fileError = 1'b1;
			end
			else
			begin
				while (!$feof(fd))
				begin
					line = "";
					void'($fgets(line, fd));
					// Comment and blank lines do not scan
					if ($sscanf(line, "%d %h %d %h", t, word, dst, data) == 4)
					begin
						testNum.push_back(t);
						instWord.push_back(word);
						wantDst.push_back(dst);
						wantData.push_back(data);
					end
				end
				$fclose(fd);
				if (testNum.size() == 0)
				begin
					$display("No instructions found in the test file");
					fileError = 1'b1;
				end
			end
		end
	endtask

	task automatic sendInst(input logic [`INST_BITS-1:0] word, input int dst, input wordT data);
		int waited;
		begin
			waited = 0;
			while (`QUEUE_DEPTH + creditsBack - sent <= 0 && waited < Timeout)
			begin
				instValid <= 1'b0;
				expPush <= 1'b0;
				@(posedge clk);
				waited++;
			end
			if (`QUEUE_DEPTH + creditsBack - sent <= 0)
			begin
				$display("Timed out waiting for an input credit at %0d ns", $time);
				timedOut = 1'b1;
			end
			else
			begin
				instValid <= 1'b1;
				inst <= word;
				expPush <= dst != NoCommitDst;
				expDst <= regIdxT'(dst);
				expData <= data;
				sent++;
				@(posedge clk);
			end
		end
	endtask

	task automatic runTest(input int t);
		int i;
		int lines;
		int count;
		int errBefore;
		int holdStart;
		int waited;
		begin
			lines = 0;
			count = 0;
			holdStart = 0;
			errBefore = errorCount + localErrors;
			if (t == 4)
			begin
				// Hold starts with every sink credit back in the DUT
				waited = 0;
				while (owed != 0 && waited < Timeout)
				begin
					@(posedge clk);
					waited++;
				end
				if (owed != 0)
				begin
					$display("Test 4: sink credits never settled before the hold");
					timedOut = 1'b1;
				end
				holdCredits <= 1'b1;
				holdStart = commitCount;
			end
			for (i = 0; i < testNum.size(); i++)
			begin
				if (testNum[i] == t && !timedOut)
				begin
					sendInst(instWord[i], wantDst[i], wantData[i]);
					lines++;
					if (wantDst[i] != NoCommitDst)
						count++;
				end
			end
			instValid <= 1'b0;
			expPush <= 1'b0;
			expTotal += count;
			if (t == 4)
			begin
				repeat (HoldCycles) @(posedge clk);
				if (commitCount - holdStart > `COMMIT_CREDITS)
				begin
					$display("Test 4: %0d commits while credits were withheld, limit is %0d",
						commitCount - holdStart, `COMMIT_CREDITS);
					localErrors++;
				end
				holdCredits <= 1'b0;
			end
			waited = 0;
			while (commitCount < expTotal && waited < Timeout)
			begin
				@(posedge clk);
				waited++;
			end
			if (commitCount < expTotal)
			begin
				$display("Test %0d: timed out with %0d of %0d commits", t, commitCount, expTotal);
				timedOut = 1'b1;
			end
			else
			begin
				// Room for a stray commit to show up
				repeat (`MULT_STAGES + 4) @(posedge clk);
				if (commitCount != expTotal)
				begin
					$display("Test %0d: %0d commits in total, expected %0d",
						t, commitCount, expTotal);
					localErrors++;
				end
				// Every word sent, NOPs included, hands its credit back
				if (creditsBack != sent)
				begin
					$display("Test %0d: %0d input credits returned for %0d words sent",
						t, creditsBack, sent);
					localErrors++;
				end
			end
			$display("Test %0d: %0d instructions, %0d commits expected, %0d errors",
				t, lines, count, errorCount + localErrors - errBefore);
		end
	endtask

	task automatic finishRun();
		int assertFails;
		begin
			assertFails = execCore_inst.reorderBuffer_inst.robAsserts.failures +
				execCore_inst.issueQueue_inst.queueAsserts.failures;
			$display("Summary: %0d commits, %0d mismatches, %0d other errors, %0d assert failures",
				commitCount, errorCount, localErrors, assertFails);
			if (errorCount + localErrors + assertFails == 0 && !timedOut && !fileError)
				$display("test passed");
			else
				$display("test failed");
			$finish;
		end
	endtask

	initial
	begin : main
		int t;
		rst <= 1'b1;
		instValid <= 1'b0;
		inst <= '0;
		expPush <= 1'b0;
		expDst <= '0;
		expData <= '0;
		holdCredits <= 1'b0;
		sent = 0;
		expTotal = 0;
		localErrors = 0;
		timedOut = 1'b0;
		fileError = 1'b0;
		loadTests();
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		for (t = 1; t <= LastTest; t++)
		begin
			if (!timedOut && !fileError)
				runTest(t);
		end
		repeat (4) @(posedge clk);
		finishRun();
	end

endmodule

`default_nettype wire

// File: all.f
+incdir+logic
logic/corePkg.sv
logic/issueQueue.sv
logic/registerFile.sv
logic/dispatchUnit.sv
logic/executeUnit.sv
logic/reorderBuffer.sv
logic/execCore.sv
verification/commitChecker.sv
verification/execCore_asserts.sv
verification/execCore_tb.sv

// File: run.sh
#!/bin/sh
# Builds execCore_tb with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/10ps --top-module execCore_tb \
	-Mdir obj_dir -f all.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/VexecCore_tb +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "test passed" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// File: verification/execCore_tests.txt
# test  instruction  dst  value   (test and dst decimal, instruction and value hex)
# dst 32 marks a NOP or unknown opcode, no commit expected
1 2A100005 1 00000005
1 2A2FFFFD 2 FFFFFFFD
1 28408000 4 00000005
2 00609000 6 0000000A
2 02730800 7 0000000D
2 00639C00 6 0000001A
2 02811800 8 FFFFFFE3
3 04912000 9 00000057
3 00A08400 10 0000000A
3 04B42000 11 00000349
3 00C20800 12 00000002
4 2AD12345 13 00012345
4 2AE80000 14 FFF80000
4 04F68400 15 0005B059
4 01073400 16 FFF92345
4 0317B800 17 000DB059
4 29280000 18 FFF92345
5 FE000000 32 00000000
5 2B300007 19 00000007
5 66100000 32 00000000
5 01498400 20 0000000C
5 FE000000 32 00000000
